// File: src/fetch_defs.svh
/*
 * prefetch subsystem sizing macros
 *   instruction byte queue depth and pointer width
 *   physical address width and segment/offset width
 */

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// queue entries, six bytes like the 8086
`define FETCH_Q_DEPTH 6

// queue pointer and count width, must hold FETCH_Q_DEPTH
`define FETCH_Q_PTR_W 3

// physical byte address width
`define FETCH_PHYS_W 20

// segment and offset width
`define FETCH_OFS_W 16

// a word holds two bytes, so the word address drops bit 0
// word address range is FETCH_PHYS_W-1 down to 1

`endif

// File: src/fetch_pkg.sv
/*
 * shared types for the prefetch subsystem
 *   mem_req_t  memory request (access strobe, word address)
 *   mem_rsp_t  memory response (ack strobe, data word)
 *   q_wr_t     byte queue write port (enable, byte, flush)
 */

`include "fetch_defs.svh"

package fetch_pkg;

    // memory request, 20 bits
    typedef struct packed {
        // held high until the ack cycle
        logic                      access;
        // word address, byte address bits 19..1
        logic [`FETCH_PHYS_W-1:1]  addr;
    } mem_req_t;

    // memory response, 17 bits
    typedef struct packed {
        // single cycle strobe
        logic        ack;
        // even byte in 7:0, odd byte in 15:8
        logic [15:0] data;
    } mem_rsp_t;

    // queue write port, 10 bits
    typedef struct packed {
        logic       wr_en;
        logic [7:0] data;
        // clears the queue, wins over pop
        logic       flush;
    } q_wr_t;

endpackage

// File: src/prefetch.sv
/*
 * prefetch unit
 *   fetch offset combined with cs into a word address
 *   splits each returned word into bytes for the queue
 *   second-byte write in the cycle after the ack
 *   abort of an access that was open when a new ip was loaded
 */

`include "fetch_defs.svh"

module prefetch
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    // segment and branch target
    input  logic [`FETCH_OFS_W-1:0] cs,
    input  logic [`FETCH_OFS_W-1:0] new_ip,
    input  logic                    load_new_ip,
    // queue side
    input  logic                    q_full,
    output q_wr_t                   q_wr,
    // memory side
    output mem_req_t                mem_req,
    input  mem_rsp_t                mem_rsp
);

    // offset of the next byte to be written to the queue
    logic [`FETCH_OFS_W-1:0] fetch_ofs;
    logic [`FETCH_OFS_W-1:0] next_ofs;
    // upper half of the last word, written one cycle later
    logic [7:0]              high_byte;
    logic                    write_second;
    // set while a stale access is still in flight
    logic                    abort_cur;
    logic                    ack_live;
    logic                    second_due;

    // an ack that belongs to the current stream
    assign ack_live = mem_rsp.ack && !abort_cur;

    // even start means the high byte still has to go in
    // a load in the ack cycle drops the rest of the word
    assign second_due = ack_live && !load_new_ip && !fetch_ofs[0];

    // look ahead by one byte during the ack
    assign next_ofs = ack_live ? fetch_ofs + 1'b1 : fetch_ofs;

    // physical = cs * 16 + offset, word address is that over two
    assign mem_req.addr = {cs, 3'b000} + {4'b0000, next_ofs[`FETCH_OFS_W-1:1]};

    // idle during the ack and the second-byte write
    // full already leaves room for one more word
    assign mem_req.access = !q_full && !mem_rsp.ack && !write_second;

    // queue write
    assign q_wr.wr_en = !abort_cur && !load_new_ip && (mem_rsp.ack || write_second);
    assign q_wr.flush = load_new_ip;

    // odd offset takes the upper half straight from the bus
    always_comb begin
        if (mem_rsp.ack) begin
            q_wr.data = fetch_ofs[0] ? mem_rsp.data[15:8] : mem_rsp.data[7:0];
        end else begin
            q_wr.data = high_byte;
        end
    end

    // abort tracking
    // an open access gets its ack later, throw it away
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            abort_cur <= 1'b0;
        end else if (load_new_ip && mem_req.access) begin
            abort_cur <= 1'b1;
        end else if (abort_cur && mem_rsp.ack) begin
            abort_cur <= 1'b0;
        end
    end

    // second byte of an even-aligned word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            write_second <= 1'b0;
        end else begin
            write_second <= second_due;
        end
    end

    // fetch offset, wraps inside the segment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_ofs <= '0;
        end else if (load_new_ip) begin
            fetch_ofs <= new_ip;
        end else if (!abort_cur && (mem_rsp.ack || write_second)) begin
            fetch_ofs <= fetch_ofs + 1'b1;
        end
    end

    // upper half kept for the following cycle
    always_ff @(posedge clk) begin
        if (mem_rsp.ack) begin
            high_byte <= mem_rsp.data[15:8];
        end
    end

endmodule

// File: src/byte_queue.sv
/*
 * instruction byte queue
 *   circular buffer with read and write pointers and a count
 *   full raised two entries early to absorb one word in flight
 *   flush clears pointers and count
 */

`include "fetch_defs.svh"

module byte_queue
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  q_wr_t      q_wr,
    input  logic       pop,
    output logic [7:0] head,
    output logic       empty,
    output logic       full
);

    localparam int depth = `FETCH_Q_DEPTH;
    localparam int ptr_w = `FETCH_Q_PTR_W;
    localparam logic [ptr_w-1:0] last_idx = ptr_w'(depth - 1);
    // room for both bytes of one outstanding word
    localparam logic [ptr_w-1:0] full_level = ptr_w'(depth - 2);

    logic [7:0]       mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] count;
    logic             do_wr;
    logic             do_pop;

    // flush wins over both sides
    assign do_wr  = q_wr.wr_en && !q_wr.flush;
    assign do_pop = pop && !empty && !q_wr.flush;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count >= full_level);

    // pointers and count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (q_wr.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves count alone
            case ({do_wr, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= q_wr.data;
        end
    end

endmodule

// File: src/instr_stream.sv
/*
 * instruction stream stage
 *   presents the queue head to the decoder
 *   pops on take while a byte is valid
 *   tracks the offset of the head byte
 */

`include "fetch_defs.svh"

module instr_stream (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`FETCH_OFS_W-1:0] new_ip,
    input  logic                    load_new_ip,
    // consumer strobe
    input  logic                    take,
    // queue read side
    input  logic [7:0]              head,
    input  logic                    empty,
    output logic                    pop,
    // decoder side
    output logic                    q_valid,
    output logic [7:0]              q_byte,
    output logic [`FETCH_OFS_W-1:0] q_ip
);

    // consumer offset
    // fetch offset runs ahead, so this is the only record of the head's offset
    logic [`FETCH_OFS_W-1:0] ip_reg;

    // head byte straight from the queue register
    assign q_valid = !empty;
    assign q_byte  = head;

    // take while nothing is valid is dropped
    assign pop = take && q_valid;

    assign q_ip = ip_reg;

    // branch load wins over a pop in the same cycle
    // increment wraps FFFF to 0000 inside the segment
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ip_reg <= '0;
        end else if (load_new_ip) begin
            ip_reg <= new_ip;
        end else if (pop) begin
            ip_reg <= ip_reg + 1'b1;
        end
    end

endmodule

// File: src/fetch_unit.sv
/*
 * prefetch subsystem top
 *   prefetch unit, instruction byte queue, stream stage
 */

`include "fetch_defs.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`FETCH_OFS_W-1:0] cs,
    input  logic [`FETCH_OFS_W-1:0] new_ip,
    input  logic                    load_new_ip,
    output mem_req_t                mem_req,
    input  mem_rsp_t                mem_rsp,
    input  logic                    take,
    output logic                    q_valid,
    output logic [7:0]              q_byte,
    output logic [`FETCH_OFS_W-1:0] q_ip
);

    q_wr_t      q_wr;
    logic       q_full;
    logic       q_empty;
    logic [7:0] q_head;
    logic       q_pop;

    // fetch side, also flushes the queue on a branch
    prefetch u_prefetch (
        .clk        (clk),
        .reset      (reset),
        .cs         (cs),
        .new_ip     (new_ip),
        .load_new_ip(load_new_ip),
        .q_full     (q_full),
        .q_wr       (q_wr),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp)
    );

    byte_queue u_byte_queue (
        .clk  (clk),
        .reset(reset),
        .q_wr (q_wr),
        .pop  (q_pop),
        .head (q_head),
        .empty(q_empty),
        .full (q_full)
    );

    // decoder side
    instr_stream u_instr_stream (
        .clk        (clk),
        .reset      (reset),
        .new_ip     (new_ip),
        .load_new_ip(load_new_ip),
        .take       (take),
        .head       (q_head),
        .empty      (q_empty),
        .pop        (q_pop),
        .q_valid    (q_valid),
        .q_byte     (q_byte),
        .q_ip       (q_ip)
    );

endmodule

// File: verif/fetch_assertions.sv
/*
 * concurrent checks for the prefetch subsystem
 *   stream bytes against the memory rule, offset step
 *   branch flush, back-pressure and queue depth, reset state
 *   bind to the subsystem top
 */

`include "fetch_defs.svh"

module fetch_assertions
    import fetch_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input logic [`FETCH_OFS_W-1:0]  cs,
    input logic [`FETCH_OFS_W-1:0]  new_ip,
    input logic                     load_new_ip,
    input mem_req_t                 mem_req,
    input logic                     take,
    input logic                     q_valid,
    input logic [7:0]               q_byte,
    input logic [`FETCH_OFS_W-1:0]  q_ip,
    input logic [`FETCH_Q_PTR_W-1:0] q_count
);

    localparam int ptr_w = `FETCH_Q_PTR_W;
    localparam logic [ptr_w-1:0] max_count  = ptr_w'(`FETCH_Q_DEPTH);
    // two entries kept free for a word in flight
    localparam logic [ptr_w-1:0] full_count = ptr_w'(`FETCH_Q_DEPTH - 2);

    int fail_count = 0;

    logic [7:0]              exp_byte;
    logic [`FETCH_OFS_W-1:0] ip_next;
    logic [`FETCH_OFS_W-1:0] ip_loaded;

    // byte at a physical address, low 8 bits xor the next 8
    function automatic logic [7:0] byte_at(input logic [15:0] seg, input logic [15:0] ofs);
        logic [`FETCH_PHYS_W-1:0] p;
        p = {seg, 4'h0} + {4'h0, ofs};
        return p[7:0] ^ p[15:8];
    endfunction

    assign exp_byte = byte_at(cs, q_ip);

    // one-cycle history for the step and flush checks
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ip_next   <= '0;
            ip_loaded <= '0;
        end else begin
            ip_next   <= q_ip + 16'd1;
            ip_loaded <= new_ip;
        end
    end

    // byte handed to the decoder
    a_stream_byte: assert property (@(posedge clk) disable iff (reset)
        (take && q_valid) |-> (q_byte == exp_byte))
    else begin
        $error("Error at %0t: q_byte is %h, expected %h", $time,
            $sampled(q_byte), $sampled(exp_byte));
        fail_count++;
    end

    // offset steps by one per pop, wraps in the segment
    a_ip_step: assert property (@(posedge clk) disable iff (reset)
        (take && q_valid && !load_new_ip) |=> (q_ip == ip_next))
    else begin
        $error("Error at %0t: q_ip is %h, expected %h", $time,
            $sampled(q_ip), $sampled(ip_next));
        fail_count++;
    end

    // branch empties the queue and sets the offset
    a_flush: assert property (@(posedge clk) disable iff (reset)
        load_new_ip |=> (!q_valid && q_ip == ip_loaded))
    else begin
        $error("Error at %0t: after a load q_valid is %b and q_ip is %h, expected 0 and %h",
            $time, $sampled(q_valid), $sampled(q_ip), $sampled(ip_loaded));
        fail_count++;
    end

    // head byte only leaves on a pop or a flush
    a_hold_valid: assert property (@(posedge clk) disable iff (reset)
        (q_valid && !take && !load_new_ip) |=> q_valid)
    else begin
        $error("q_valid dropped with no take and no load");
        fail_count++;
    end

    // nothing taken, so the queue stays at the threshold and the bus stays quiet
    a_full_idle: assert property (@(posedge clk) disable iff (reset)
        (q_count >= full_count && !take && !load_new_ip) |=> !mem_req.access)
    else begin
        $error("memory access requested while the queue is held at the full threshold");
        fail_count++;
    end

    a_depth: assert property (@(posedge clk) disable iff (reset)
        q_count <= max_count)
    else begin
        $error("queue holds more bytes than its depth");
        fail_count++;
    end

    // quiet during reset and in the first cycle after
    a_reset_quiet: assert property (@(posedge clk)
        reset |-> (!q_valid && q_ip == '0))
    else begin
        $error("Error at %0t: in reset q_valid is %b and q_ip is %h, expected 0 and 0000",
            $time, $sampled(q_valid), $sampled(q_ip));
        fail_count++;
    end

    a_reset_exit: assert property (@(posedge clk)
        $fell(reset) |-> (!q_valid && q_ip == '0 && mem_req.access))
    else begin
        $error("wrong state in the first cycle after reset");
        fail_count++;
    end

endmodule

bind fetch_unit fetch_assertions u_fetch_assertions (
    .clk        (clk),
    .reset      (reset),
    .cs         (cs),
    .new_ip     (new_ip),
    .load_new_ip(load_new_ip),
    .mem_req    (mem_req),
    .take       (take),
    .q_valid    (q_valid),
    .q_byte     (q_byte),
    .q_ip       (q_ip),
    .q_count    (u_byte_queue.count)
);

// File: verif/fetch_tb.sv
/*
 * testbench for the prefetch subsystem
 *   clock, reset, memory model with random ack delay
 *   random consumer, branch loads at even, odd and wrapping offsets
 *   back-pressure hold with take low, closing error count
 */

`include "fetch_defs.svh"

module fetch_tb
    import fetch_pkg::*;
();

    logic                     clk;
    logic                     reset;
    logic [`FETCH_OFS_W-1:0]  cs;
    logic [`FETCH_OFS_W-1:0]  new_ip;
    logic                     load_new_ip;
    mem_req_t                 mem_req;
    mem_rsp_t                 mem_rsp;
    logic                     take;
    logic                     q_valid;
    logic [7:0]               q_byte;
    logic [`FETCH_OFS_W-1:0]  q_ip;

    // memory model state
    logic [`FETCH_PHYS_W-1:1] req_addr;
    logic                     mem_busy;
    logic [1:0]               ack_wait;

    logic [15:0] lfsr = 16'd52;
    int          timeouts = 0;

    fetch_unit u_fetch_unit (
        .clk        (clk),
        .reset      (reset),
        .cs         (cs),
        .new_ip     (new_ip),
        .load_new_ip(load_new_ip),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .take       (take),
        .q_valid    (q_valid),
        .q_byte     (q_byte),
        .q_ip       (q_ip)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one step per bit taken
    function automatic logic [3:0] rand_bits(input int n);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [7:0] byte_rule(input logic [`FETCH_PHYS_W-1:0] p);
        return p[7:0] ^ p[15:8];
    endfunction

    // even byte low, odd byte high
    function automatic logic [15:0] word_at(input logic [`FETCH_PHYS_W-1:1] w);
        return {byte_rule({w, 1'b1}), byte_rule({w, 1'b0})};
    endfunction

    // memory, one ack cycle after 1 to 4 cycles
    always @(posedge clk) begin
        if (reset) begin
            mem_rsp  <= '0;
            mem_busy <= 1'b0;
            ack_wait <= '0;
        end else if (mem_rsp.ack) begin
            mem_rsp <= '0;
        end else if (mem_busy) begin
            if (ack_wait == 2'd0) begin
                mem_rsp.ack  <= 1'b1;
                mem_rsp.data <= word_at(req_addr);
                mem_busy     <= 1'b0;
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end else if (mem_req.access) begin
            req_addr <= mem_req.addr;
            mem_busy <= 1'b1;
            ack_wait <= 2'(rand_bits(2));
        end
    end

    task automatic end_run();
        int fails;
        fails = u_fetch_unit.u_fetch_assertions.fail_count;
        $display("closing: %0d assertion failures, %0d timeouts", fails, timeouts);
        if (fails == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    // random take each cycle
    task automatic consume(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            take <= (rand_bits(1) != 4'd0);
        end
    endtask

    // called right after a rising edge
    task automatic load_ip(input logic [`FETCH_OFS_W-1:0] ofs);
        new_ip      <= ofs;
        load_new_ip <= 1'b1;
        @(posedge clk);
        load_new_ip <= 1'b0;
    endtask

    // returns on the edge where the memory takes a new request
    // the access is then still open in the following cycle
    task automatic wait_access();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!(mem_req.access && !mem_busy) && n < 100);
        if (!(mem_req.access && !mem_busy)) begin
            $display("timeout waiting for a memory access");
            timeouts++;
            end_run();
        end
    endtask

    task automatic wait_full();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!u_fetch_unit.u_byte_queue.full && n < 200);
        if (!u_fetch_unit.u_byte_queue.full) begin
            $display("timeout waiting for the queue to fill");
            timeouts++;
            end_run();
        end
    endtask

    initial begin
        reset       = 1'b1;
        cs          = 16'h1234;
        new_ip      = '0;
        load_new_ip = 1'b0;
        take        = 1'b0;
        mem_rsp     = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        // stream from offset zero
        consume(300);
        // even and odd starts, each while an access is open
        // keep draining so a request can go out
        take <= 1'b1;
        wait_access();
        load_ip(16'h0100);
        consume(200);
        take <= 1'b1;
        wait_access();
        load_ip(16'h0233);
        consume(200);
        // crosses FFFF to 0000
        load_ip(16'hFFFE);
        consume(100);
        // back-pressure, then a load with the bus idle
        take <= 1'b0;
        wait_full();
        repeat (20) @(posedge clk);
        load_ip(16'h0401);
        consume(200);
        // new segment, physical address wraps at 20 bits
        cs   <= 16'hF00D;
        take <= 1'b0;
        load_ip(16'hFFF1);
        consume(200);
        take <= 1'b0;
        repeat (2) @(posedge clk);
        end_run();
    end

endmodule

// File: sim.f
+incdir+src
src/fetch_pkg.sv
src/prefetch.sv
src/byte_queue.sv
src/instr_stream.sv
src/fetch_unit.sv
verif/fetch_assertions.sv
verif/fetch_tb.sv

// File: Makefile
# Verilator build and run of the prefetch subsystem testbench

SRCS := $(shell grep -v '^+' sim.f) src/fetch_defs.svh

all: run

obj_dir/Vfetch_tb: sim.f $(SRCS)
	verilator --binary --timing --assert -f sim.f --top-module fetch_tb

# status comes from the search for the pass line
run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -q "Regression passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean
